// ==== design/text_layer_macros.svh ====
`ifndef TEXT_LAYER_MACROS_SVH
`define TEXT_LAYER_MACROS_SVH

// visible pixels per scanline
`define TEXT_LINE_WIDTH 320

// 40 visible columns plus one for the fine scroll spill
`define TEXT_TILE_COLS 41

// fixed offset the hardware adds to every scroll word
`define TEXT_SCROLL_BIAS 6'h2B

// text pens live in the upper half of the palette
`define TEXT_PAL_BASE 11'h400

`endif

// ==== design/text_video_pkg.sv ====
package text_video_pkg;

    // horizontal counter or line buffer location
    typedef logic [8:0] hpos_t;

    typedef logic [8:0] vpos_t;  // scanline number

    // strobes and counters from the video timing generator
    typedef struct packed {
        logic  hb;         // horizontal blank
        logic  vb;         // vertical blank
        logic  active;     // visible area
        logic  pixel_cen;  // one pulse per output pixel
        vpos_t vrender;    // line being rendered
        hpos_t h;          // playback position
    } video_timing_t;

endpackage

// ==== design/text_tile_pkg.sv ====
package text_tile_pkg;

    // one text VRAM word
    typedef struct packed {
        logic [5:0] bank;   // colour bank
        logic [9:0] index;  // tile number in the text ROM
    } tile_code_t;

    // eight pens of one tile row, leftmost pen in the top nibble
    typedef logic [31:0] tile_row_t;

    typedef logic [3:0] pen_t;

    // palette index sent to the mixer
    typedef logic [10:0] text_pixel_t;

    // pen at column idx of a tile row, 0 is the leftmost
    function automatic pen_t row_pen(tile_row_t row, logic [2:0] idx);
        logic [2:0] nib;
        nib = 3'd7 - idx;
        return row[4 * nib +: 4];
    endfunction

endpackage

// ==== design/text_line_if.sv ====
interface text_line_if;

    logic        line_valid;   // single cycle, descriptor below is valid
    logic [11:0] row_base;     // first VRAM word of the 64 column row
    logic [5:0]  start_col;    // coarse scroll in tiles
    logic [2:0]  fine_scroll;  // pixels dropped from the first tile
    logic [2:0]  tile_line;    // row inside each 8x8 tile

    modport setup (
        output line_valid,
        output row_base,
        output start_col,
        output fine_scroll,
        output tile_line
    );

    modport fetch (
        input line_valid,
        input row_base,
        input start_col,
        input fine_scroll,
        input tile_line
    );

endinterface

// ==== design/text_line_setup.sv ====
`include "text_layer_macros.svh"

module text_line_setup (
    input  logic                  clk96,
    input  logic                  reset96,
    input  logic                  hb,
    input  logic                  vb,
    input  text_video_pkg::vpos_t vrender,
    output logic [7:0]            select_addr,
    output logic [7:0]            scroll_addr,
    input  logic [15:0]           select_data,
    input  logic [15:0]           scroll_data,
    text_line_if.setup            line
);

    logic        hb_d;
    logic        hb_fall;
    logic        start;
    logic [2:0]  req_pipe;  // read in flight, one bit per cycle of latency
    logic [15:0] biased;

    assign hb_fall = hb_d & ~hb;
    assign start   = hb_fall & ~vb;  // no renders during vertical blank

    // scroll word as the hardware sees it
    assign biased = scroll_data + 16'(`TEXT_SCROLL_BIAS);

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            hb_d            <= 1'b0;
            req_pipe        <= '0;
            select_addr     <= '0;
            scroll_addr     <= '0;
            line.line_valid <= 1'b0;
        end else begin
            hb_d     <= hb;
            req_pipe <= {req_pipe[1:0], start};
            if (start) begin
                select_addr <= vrender[7:0];  // both tables indexed by line
                scroll_addr <= vrender[7:0];
            end
            // data is back two cycles after the address
            line.line_valid <= req_pipe[2];
        end
    end

    always_ff @(posedge clk96) begin
        if (req_pipe[2]) begin
            line.row_base    <= {select_data[8:3], 6'b000000};
            line.tile_line   <= select_data[2:0];
            line.start_col   <= biased[8:3];
            line.fine_scroll <= biased[2:0];
        end
    end

    // the fetcher needs at least this gap to see each descriptor once
    a_valid_spacing: assert property (
        @(posedge clk96) disable iff (reset96)
        line.line_valid |=> !line.line_valid [*3]
    ) else $error("line_valid repeated within 3 cycles");

endmodule

// ==== design/text_tile_fetch.sv ====
`include "text_layer_macros.svh"

module text_tile_fetch (
    input  logic                       clk96,
    input  logic                       reset96,
    text_line_if.fetch                 line,
    input  logic                       flipx,
    output logic [11:0]                vram_addr,
    input  text_tile_pkg::tile_code_t  vram_data,
    output logic [13:0]                rom_addr,
    input  logic [15:0]                rom_data,
    output logic                       wr_en,
    output text_video_pkg::hpos_t      wr_addr,
    output text_tile_pkg::text_pixel_t wr_data
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WRITE
    } state_t;

    state_t                     state;
    logic [2:0]                 step;  // cycle in FETCH, pen index in WRITE
    logic [5:0]                 col;
    logic                       last_col;
    logic [5:0]                 next_col;

    // descriptor held for the whole line
    logic [11:0]                row_base_q;
    logic [5:0]                 start_col_q;
    logic [2:0]                 fine_q;
    logic [2:0]                 tile_line_q;

    logic [5:0]                 bank_q;
    text_tile_pkg::tile_row_t   row_q;
    text_tile_pkg::pen_t        pen;
    logic signed [10:0]         pos;
    logic                       in_line;
    text_video_pkg::hpos_t      dest;
    text_tile_pkg::text_pixel_t colour;

    assign last_col = (col == `TEXT_TILE_COLS - 1);
    assign next_col = col + 6'd1 + start_col_q;  // wraps at 64 columns

    // screen x is 8*col + pen index, minus the fine scroll
    assign pos     = $signed({2'b00, col, step}) - $signed({8'b00000000, fine_q});
    assign in_line = (pos >= 0) && (pos < `TEXT_LINE_WIDTH);
    assign dest    = flipx ? text_video_pkg::hpos_t'(`TEXT_LINE_WIDTH - 1) - pos[8:0]
                           : pos[8:0];

    assign pen    = text_tile_pkg::row_pen(row_q, step);
    assign colour = (pen == 4'd0) ? '0 : (`TEXT_PAL_BASE | {1'b0, bank_q, pen});

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state     <= IDLE;
            step      <= '0;
            col       <= '0;
            vram_addr <= '0;
            rom_addr  <= '0;
            wr_en     <= 1'b0;
        end else begin
            wr_en <= (state == WRITE) && in_line;
            case (state)
                IDLE: begin
                    if (line.line_valid) begin
                        state     <= FETCH;
                        step      <= '0;
                        col       <= '0;
                        vram_addr <= line.row_base + {6'b000000, line.start_col};
                    end
                end
                FETCH: begin
                    step <= step + 3'd1;
                    case (step)
                        3'd2: rom_addr <= {vram_data.index, tile_line_q, 1'b0};  // upper half
                        3'd3: rom_addr <= {rom_addr[13:1], 1'b1};  // lower half
                        3'd5: begin
                            state <= WRITE;
                            step  <= '0;
                        end
                        default: ;
                    endcase
                end
                WRITE: begin
                    step <= step + 3'd1;
                    if (step == 3'd7) begin
                        if (last_col) begin
                            state <= IDLE;
                        end else begin
                            state     <= FETCH;
                            col       <= col + 6'd1;
                            vram_addr <= row_base_q + {6'b000000, next_col};
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk96) begin
        if (state == IDLE && line.line_valid) begin
            row_base_q  <= line.row_base;
            start_col_q <= line.start_col;
            fine_q      <= line.fine_scroll;
            tile_line_q <= line.tile_line;
        end
        if (state == FETCH && step == 3'd2)
            bank_q <= vram_data.bank;
        if (state == FETCH && step == 3'd5)
            row_q[31:16] <= rom_data;  // pens 0..3
        // low half lands while pen 0 is being written
        if (state == WRITE && step == 3'd0)
            row_q[15:0] <= rom_data;
        wr_addr <= dest;
        wr_data <= colour;
    end

    a_wr_in_line: assert property (
        @(posedge clk96) disable iff (reset96)
        wr_en |-> wr_addr < `TEXT_LINE_WIDTH
    ) else $error("line buffer write outside the visible line");

    // columns wrap inside the 64 word row picked by the select table
    a_vram_in_row: assert property (
        @(posedge clk96) disable iff (reset96)
        (state != IDLE) |-> vram_addr[11:6] == row_base_q[11:6]
    ) else $error("VRAM read left the selected row");

endmodule

// ==== design/text_line_buffer.sv ====
module text_line_buffer #(
    parameter type payload_t = text_tile_pkg::text_pixel_t
) (
    input  logic                  clk96,
    input  logic                  reset96,
    input  logic                  hb,
    input  logic                  pixel_cen,
    input  logic                  active,
    input  logic                  wr_en,
    input  text_video_pkg::hpos_t wr_addr,
    input  payload_t              wr_data,
    input  text_video_pkg::hpos_t h,
    output payload_t              pixel
);

    localparam int DEPTH = 2 ** $bits(text_video_pkg::hpos_t);

    // both banks in one array, bank select is the top address bit
    payload_t mem [2 * DEPTH];

    logic hb_d;
    logic swap;
    logic rd_bank;  // bank being played back
    logic rd_en;

    assign swap  = hb_d & ~hb;
    assign rd_en = pixel_cen & active;

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            hb_d    <= 1'b0;
            rd_bank <= 1'b0;
            pixel   <= '0;
        end else begin
            hb_d <= hb;
            if (swap)
                rd_bank <= ~rd_bank;
            if (rd_en)
                pixel <= mem[{rd_bank, h}];
        end
    end

    always_ff @(posedge clk96) begin
        if (wr_en)
            mem[{~rd_bank, wr_addr}] <= wr_data;
        // read locations start the next line transparent
        if (rd_en)
            mem[{rd_bank, h}] <= '0;
    end

    // a write on the swap edge would land in the bank about to play
    a_no_write_on_swap: assert property (
        @(posedge clk96) disable iff (reset96)
        wr_en |-> !swap
    ) else $error("render still writing when the banks swapped");

endmodule

// ==== design/extra_text_layer.sv ====
module extra_text_layer (
    input  logic                       clk96,
    input  logic                       reset96,
    input  logic                       hb,
    input  logic                       vb,
    input  logic                       active,
    input  logic                       pixel_cen,
    input  logic                       flipx,
    input  text_video_pkg::vpos_t      vrender,
    input  text_video_pkg::hpos_t      h,
    output logic [7:0]                 select_addr,
    input  logic [15:0]                select_data,
    output logic [7:0]                 scroll_addr,
    input  logic [15:0]                scroll_data,
    output logic [11:0]                vram_addr,
    input  logic [15:0]                vram_data,
    output logic [13:0]                rom_addr,
    input  logic [15:0]                rom_data,
    output text_tile_pkg::text_pixel_t text_pixel
);

    text_line_if line_if ();

    // fetcher to line buffer write port
    logic                       wr_en;
    text_video_pkg::hpos_t      wr_addr;
    text_tile_pkg::text_pixel_t wr_data;

    text_line_setup u_setup (
        .clk96       (clk96),
        .reset96     (reset96),
        .hb          (hb),
        .vb          (vb),
        .vrender     (vrender),
        .select_addr (select_addr),
        .scroll_addr (scroll_addr),
        .select_data (select_data),
        .scroll_data (scroll_data),
        .line        (line_if.setup)
    );

    text_tile_fetch u_fetch (
        .clk96     (clk96),
        .reset96   (reset96),
        .line      (line_if.fetch),
        .flipx     (flipx),
        .vram_addr (vram_addr),
        .vram_data (vram_data),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    text_line_buffer #(
        .payload_t (text_tile_pkg::text_pixel_t)
    ) u_line_buffer (
        .clk96     (clk96),
        .reset96   (reset96),
        .hb        (hb),
        .pixel_cen (pixel_cen),
        .active    (active),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .h         (h),
        .pixel     (text_pixel)
    );

endmodule

// ==== sim/text_layer_model.sv ====
`include "text_layer_macros.svh"

package text_layer_model;

    localparam int MEM_SELECT = 0;
    localparam int MEM_SCROLL = 1;
    localparam int MEM_VRAM   = 2;
    localparam int MEM_ROM    = 3;

    logic [15:0] select_mem [256];  // tile row select per line
    logic [15:0] scroll_mem [256];
    logic [15:0] vram_mem [4096];
    logic [15:0] rom_mem [16384];   // two words per tile row

    // line buffer contents expected after one render
    text_tile_pkg::text_pixel_t next_line [`TEXT_LINE_WIDTH];

    function automatic logic [15:0] mem_read(input int kind, input int addr);
        case (kind)
            MEM_SELECT: return select_mem[addr];
            MEM_SCROLL: return scroll_mem[addr];
            MEM_VRAM:   return vram_mem[addr];
            default:    return rom_mem[addr];
        endcase
    endfunction

    function automatic void render_line(input int v, input bit flip);
        logic [15:0] sel;
        logic [15:0] biased;
        logic [15:0] code;
        logic [31:0] row;
        logic [3:0]  pen;
        int          row_base;
        int          start_col;
        int          fine;
        int          tile_line;
        int          rom_a;
        int          bank;
        int          pos;
        sel       = select_mem[v % 256];
        biased    = scroll_mem[v % 256] + 16'(`TEXT_SCROLL_BIAS);
        start_col = (biased >> 3) & 63;
        fine      = biased & 7;
        tile_line = sel & 7;
        row_base  = ((sel & 16'hFFF8) << 3) & 12'hFFF;
        foreach (next_line[i])
            next_line[i] = '0;
        for (int x = 0; x < `TEXT_TILE_COLS; x++) begin
            code  = vram_mem[row_base + ((x + start_col) & 63)];  // columns wrap at 64
            rom_a = code[9:0] * 16 + tile_line * 2;
            row   = {rom_mem[rom_a], rom_mem[rom_a + 1]};  // first word is the left half
            bank  = code[15:10];
            for (int t = 0; t < 8; t++) begin
                pen = row[31 - 4 * t -: 4];
                pos = 8 * x - fine + t;
                if (pos >= 0 && pos < `TEXT_LINE_WIDTH) begin
                    if (flip)
                        pos = `TEXT_LINE_WIDTH - 1 - pos;
                    // pen 0 is transparent
                    next_line[pos] = (pen == 0) ? '0 : 11'(`TEXT_PAL_BASE + bank * 16 + pen);
                end
            end
        end
    endfunction

endpackage

module mem_model #(
    parameter int KIND = text_layer_model::MEM_ROM,
    parameter int AW   = 14
) (
    input  logic          clk96,
    input  logic [AW-1:0] addr,
    output logic [15:0]   data
);

    logic [15:0] stage;  // first of two read registers

    always_ff @(posedge clk96) begin
        stage <= text_layer_model::mem_read(KIND, int'(addr));
        data  <= stage;
    end

endmodule

// ==== sim/tb_extra_text_layer.sv ====
`include "text_layer_macros.svh"

module tb_extra_text_layer;

    logic                       clk96;
    logic                       reset96;
    logic                       hb, vb, active, pixel_cen, flipx;
    text_video_pkg::vpos_t      vrender;
    text_video_pkg::hpos_t      h;
    logic [7:0]                 select_addr, scroll_addr;
    logic [11:0]                vram_addr;
    logic [13:0]                rom_addr;
    logic [15:0]                select_data, scroll_data, vram_data, rom_data;
    text_tile_pkg::text_pixel_t text_pixel;

    // line playing now, and the one rendered while it plays
    text_tile_pkg::text_pixel_t exp_cur [`TEXT_LINE_WIDTH];
    text_tile_pkg::text_pixel_t pending [`TEXT_LINE_WIDTH];
    bit exp_known = 1'b0;
    bit pending_known = 1'b0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    extra_text_layer UUT (.*);

    mem_model #(.KIND(text_layer_model::MEM_SELECT), .AW(8))
        u_select_mem (.clk96, .addr(select_addr), .data(select_data));
    mem_model #(.KIND(text_layer_model::MEM_SCROLL), .AW(8))
        u_scroll_mem (.clk96, .addr(scroll_addr), .data(scroll_data));
    mem_model #(.KIND(text_layer_model::MEM_VRAM), .AW(12))
        u_vram (.clk96, .addr(vram_addr), .data(vram_data));
    mem_model #(.KIND(text_layer_model::MEM_ROM), .AW(14))
        u_rom (.clk96, .addr(rom_addr), .data(rom_data));

    initial begin
        clk96 = 1'b0;
        forever #50 clk96 = ~clk96;
    end

    initial begin  // bound on the whole run
        repeat (60000) @(posedge clk96);
        $display("timeout, the run did not finish within 60000 clock cycles");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s expected 0x%0h got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 16384; i++) begin
            text_layer_model::rom_mem[i] = 16'($urandom);
            if (i < 4096)
                text_layer_model::vram_mem[i] = 16'($urandom);
            if (i < 256) begin
                text_layer_model::select_mem[i] = 16'($urandom);
                text_layer_model::scroll_mem[i] = 16'($urandom);
            end
        end
    endtask

    // one scanline of 400 positions, 4 clocks each, hb over the last 80
    task automatic run_line(input int v, input bit blank);
        logic [7:0] prev_addr;
        bit         started;
        prev_addr = select_addr;
        started   = 1'b0;
        exp_cur   = pending;
        exp_known = pending_known;
        if (blank) begin
            foreach (pending[i])
                pending[i] = '0;  // cleared while this line plays
        end else begin
            text_layer_model::render_line(v, flipx);
            pending = text_layer_model::next_line;
        end
        pending_known = 1'b1;
        for (int x = 0; x < 400; x++) begin
            for (int c = 0; c < 4; c++) begin
                @(negedge clk96);
                if (c == 0 && x > 0 && x <= `TEXT_LINE_WIDTH && exp_known)
                    check_value($sformatf("text_pixel[%0d]", x - 1), 16'(text_pixel),
                                16'(exp_cur[x - 1]));
                if (x < 4 && select_addr == 8'(v))
                    started = 1'b1;
                if (x == 4 && c == 0) begin
                    if (blank)
                        assert (select_addr == prev_addr)
                            else report_problem("a render started during vertical blank");
                    else
                        assert (started)
                            else report_problem("no render started within 16 clocks of hblank end");
                end
                h         = 9'(x);
                hb        = (x >= `TEXT_LINE_WIDTH);
                active    = (x < `TEXT_LINE_WIDTH);
                vb        = blank;
                vrender   = 9'(v);
                pixel_cen = (c == 3);  // hb falls three clocks before the first read
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        void'($urandom(32'h4229_b2e1));
        reset96   = 1'b1;
        hb        = 1'b1;
        vb        = 1'b0;
        active    = 1'b0;
        pixel_cen = 1'b0;
        flipx     = 1'b0;
        vrender   = '0;
        h         = '0;
        fill_memories();
        repeat (3) @(negedge clk96);
        reset96 = 1'b0;
        @(negedge clk96);
        check_value("text_pixel", 16'(text_pixel), 16'h0);
        check_value("select_addr", 16'(select_addr), 16'h0);
        check_value("scroll_addr", 16'(scroll_addr), 16'h0);
        check_value("vram_addr", 16'(vram_addr), 16'h0);
        check_value("rom_addr", 16'(rom_addr), 16'h0);
        finish_test("reset values");

        for (int i = 0; i < 256; i++) begin
            text_layer_model::select_mem[i] = '0;
            text_layer_model::scroll_mem[i] = '0;
        end
        for (int v = 1; v <= 3; v++)
            run_line(v, 1'b0);
        finish_test("zero scroll");

        for (int i = 0; i < 256; i++)
            text_layer_model::scroll_mem[i] = 16'($urandom);
        for (int v = 4; v <= 5; v++)
            run_line(v, 1'b0);
        finish_test("random scroll");

        for (int i = 0; i < 256; i++)
            text_layer_model::select_mem[i] = 16'($urandom);
        for (int v = 6; v <= 13; v++)
            run_line(v, 1'b0);
        finish_test("per line select");

        flipx = 1'b1;
        for (int v = 14; v <= 16; v++)
            run_line(v, 1'b0);
        finish_test("horizontal flip");

        flipx = 1'b0;
        run_line(17, 1'b1);
        run_line(18, 1'b0);  // plays back all zeros
        run_line(19, 1'b0);
        finish_test("vertical blank");

        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/text_video_pkg.sv
design/text_tile_pkg.sv
design/text_line_if.sv
design/text_line_setup.sv
design/text_tile_fetch.sv
design/text_line_buffer.sv
design/extra_text_layer.sv
sim/text_layer_model.sv
sim/tb_extra_text_layer.sv

// ==== Bender.yml ====
package:
  name: extra_text_layer

sources:
  - include_dirs:
      - design
    files:
      - design/text_video_pkg.sv
      - design/text_tile_pkg.sv
      - design/text_line_if.sv
      - design/text_line_setup.sv
      - design/text_tile_fetch.sv
      - design/text_line_buffer.sv
      - design/extra_text_layer.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/text_layer_model.sv
      - sim/tb_extra_text_layer.sv
